// ==== src.f ====
+incdir+.
video_pkg.sv
control_pkg.sv
dip_switch_loader.sv
color_overlay.sv
paddle_tracker.sv
paddle_pulse_gen.sv
breakout_cabinet_top.sv
tb_breakout_cabinet.sv

// ==== Bender.yml ====
package:
  name: breakout_cabinet

sources:
  - files:
      - video_pkg.sv
      - control_pkg.sv
      - dip_switch_loader.sv
      - color_overlay.sv
      - paddle_tracker.sv
      - paddle_pulse_gen.sv
      - breakout_cabinet_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_breakout_cabinet.sv

// ==== tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Running totals for the closing summary line
int check_count = 0;
int error_count = 0;

// Any failure that is not a value compare
task automatic report_failure(input string what);
	error_count++;
	$display("ERROR at %0t ns: %0s", $time, what);
endtask

//////////////////////////////////////////////////////////////////////
// Compare tasks for each kind of DUT result
//////////////////////////////////////////////////////////////////////
task automatic check_bit(input string name, input logic actual, input logic expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH at %0t ns: %0s = %0b, expected %0b",
			$time, name, actual, expected);
	end
endtask

// Colour word shown as three hex digits r g b
task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH at %0t ns: %0s = %03h, expected %03h",
			$time, name, actual, expected);
	end
endtask

// Decoded DIP switches shown as s1/s2/s3/s4
task automatic check_switches(input string name, input game_switches_t actual,
	input game_switches_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH at %0t ns: %0s = %h/%b/%b/%b, expected %h/%b/%b/%b",
			$time, name, actual.s1, actual.s2, actual.s3, actual.s4,
			expected.s1, expected.s2, expected.s3, expected.s4);
	end
endtask

// Paddle position as measured in lines of pad pulse
task automatic check_pos(input string name, input pos_t actual, input pos_t expected);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("MISMATCH at %0t ns: position %0s = %0d, expected %0d",
			$time, name, actual, expected);
	end
endtask

`endif

// ==== tb_breakout_cabinet.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_breakout_cabinet import video_pkg::*, control_pkg::*; ();

	logic              clk_sys;
	logic              reset;
	host_write_t       host_wr;
	cabinet_settings_t settings;
	core_video_t       core;
	logic              pad_en_n;
	logic [7:0]        joy1;
	logic [7:0]        joy2;
	spinner_t          spin1;
	spinner_t          spin2;
	pos_t              paddle1;
	pos_t              paddle2;
	video_out_t        video;
	logic              pad_out;
	game_switches_t    switches;
	logic              coin1;
	logic              coin2;
	logic              p1_start_n;
	logic              p2_start_n;
	logic              p1_serve_n;
	logic              p2_serve_n;

	`include "tb_checks.svh"

	breakout_cabinet_top #(
		.DIGITAL_STEP_SLOW (4),
		.DIGITAL_STEP_FAST (8)
	) dut (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.host_wr    (host_wr),
		.settings   (settings),
		.core       (core),
		.pad_en_n   (pad_en_n),
		.joy1       (joy1),
		.joy2       (joy2),
		.spin1      (spin1),
		.spin2      (spin2),
		.paddle1    (paddle1),
		.paddle2    (paddle2),
		.video      (video),
		.pad_out    (pad_out),
		.switches   (switches),
		.coin1      (coin1),
		.coin2      (coin2),
		.p1_start_n (p1_start_n),
		.p2_start_n (p2_start_n),
		.p1_serve_n (p1_serve_n),
		.p2_serve_n (p2_serve_n)
	);

	// 40 ns system clock
	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus helpers that drive right after a falling edge
	//////////////////////////////////////////////////////////////////////
	// Quiet cabinet in digital mode with no overlay options
	task automatic drive_idle();
		host_wr  = '0;
		settings = '0;
		core     = '0;
		pad_en_n = 1'b1;
		joy1     = '0;
		joy2     = '0;
		spin1    = '0;
		spin2    = '0;
		paddle1  = '0;
		paddle2  = '0;
	endtask

	task automatic apply_reset();
		@(negedge clk_sys);
		drive_idle();
		reset = 1'b1;
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// One host write with the switches valid on return
	task automatic write_dip(input logic [15:0] idx, input logic [26:0] adr,
		input logic [7:0] value);
		@(negedge clk_sys);
		host_wr = '{wr: 1'b1, index: idx, addr: adr, data: value};
		@(negedge clk_sys);
		host_wr.wr = 1'b0;
	endtask

	// Frame strobes for the digital stick
	task automatic pulse_vsync(input int frames);
		repeat (frames) begin
			@(negedge clk_sys);
			core.vsync = 1'b1;
			repeat (2) @(negedge clk_sys);
			core.vsync = 1'b0;
			repeat (2) @(negedge clk_sys);
		end
	endtask

	// Clear the line counter then step hsync and count lines with pad_out high
	task automatic measure_pos(output int lines);
		@(negedge clk_sys);
		pad_en_n = 1'b0;
		@(negedge clk_sys);
		pad_en_n = 1'b1;
		lines = 0;
		while (pad_out === 1'b1 && lines < 300) begin
			core.hsync = 1'b1;
			@(negedge clk_sys);
			core.hsync = 1'b0;
			@(negedge clk_sys);
			lines++;
		end
		if (lines >= 300) begin
			report_failure("pad_out stayed high for 300 lines, no end of pad pulse seen");
		end
	endtask

	task automatic expect_pos(input string name, input pos_t expected);
		int lines;
		measure_pos(lines);
		check_pos(name, pos_t'(lines), expected);
	endtask

	task automatic end_test(input string name, input int errors_before);
		$display("test %0s finished, %0d new errors", name, error_count - errors_before);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic dip_load_test();
		int             start;
		logic [7:0]     b;
		game_switches_t expected;
		start = error_count;
		apply_reset();
		check_switches("switches after reset", switches, '0);
		// Bit 0 lands in the top bit of s1 and bit 7 is ignored
		write_dip(16'd254, 27'd0, 8'hD1);
		expected.s1 = 4'b1000;
		expected.s2 = 1'b1;
		expected.s3 = 1'b0;
		expected.s4 = 1'b1;
		check_switches("switches after DIP write D1", switches, expected);
		b = 8'($urandom);
		write_dip(16'd254, 27'd0, b);
		// S1 bits arrive in reversed order
		for (int i = 0; i < 4; i++) begin
			expected.s1[i] = b[3 - i];
		end
		expected.s2 = b[4];
		expected.s3 = b[5];
		expected.s4 = b[6];
		check_switches("switches after DIP write", switches, expected);
		// Wrong index and wrong address are both ignored
		write_dip(16'd253, 27'd0, ~b);
		check_switches("switches after other index", switches, expected);
		write_dip(16'd254, 27'd1, ~b);
		check_switches("switches after nonzero addr", switches, expected);
		end_test("dip_load", start);
	endtask

	// Random column inside a band lit by one random layer and then unlit
	task automatic check_band(input logic [7:0] lo, input logic [7:0] hi, input rgb_t color);
		logic [7:0] h;
		h = lo + 8'($urandom % (hi - lo + 1));
		@(negedge clk_sys);
		core.h_count = h;
		{core.playfield, core.ball, core.score, core.pad} = 4'b0001 << ($urandom % 4);
		@(negedge clk_sys);
		check_rgb($sformatf("rgb lit at h_count %0d", h), video.rgb, color);
		{core.playfield, core.ball, core.score, core.pad} = 4'b0000;
		@(negedge clk_sys);
		check_rgb($sformatf("rgb unlit at h_count %0d", h), video.rgb, 12'h000);
	endtask

	task automatic overlay_test();
		int start;
		start = error_count;
		apply_reset();
		for (int cocktail = 0; cocktail < 2; cocktail++) begin
			// S2 selects the cocktail overlay
			write_dip(16'd254, 27'd0, (cocktail != 0) ? 8'h10 : 8'h00);
			check_band(8'd64, 8'd71, 12'hA21);
			check_band(8'd72, 8'd79, 12'hC81);
			check_band(8'd80, 8'd87, 12'h173);
			check_band(8'd88, 8'd95, 12'hCC3);
			// Player 2 rows appear only on the cocktail overlay
			check_band(8'd184, 8'd191, (cocktail != 0) ? 12'hA21 : 12'hFFF);
			check_band(8'd176, 8'd183, (cocktail != 0) ? 12'hC81 : 12'hFFF);
			check_band(8'd168, 8'd175, (cocktail != 0) ? 12'h173 : 12'hFFF);
			check_band(8'd160, 8'd167, (cocktail != 0) ? 12'hCC3 : 12'hFFF);
			// Blue strip is upright only
			check_band(8'd211, 8'd219, (cocktail != 0) ? 12'hFFF : 12'h17C);
			check_band(8'd100, 8'd150, 12'hFFF);
		end
		end_test("overlay", start);
	endtask

	// One video point with blanking and sync checked one clock later
	task automatic video_case(input logic [7:0] h, input logic [7:0] v, input logic vs,
		input logic exp_hblank, input logic exp_vblank, input logic exp_vsync);
		@(negedge clk_sys);
		core.h_count = h;
		core.v_count = v;
		core.vsync   = vs;
		@(negedge clk_sys);
		check_bit($sformatf("hblank at h %0d v %0d", h, v), video.hblank, exp_hblank);
		check_bit($sformatf("vblank at h %0d v %0d", h, v), video.vblank, exp_vblank);
		check_bit($sformatf("vsync at h %0d v %0d", h, v), video.vsync, exp_vsync);
	endtask

	task automatic blank_sync_test();
		int start;
		start = error_count;
		apply_reset();
		// Upright cabinet keeps the player 1 limits for player2
		core.player2 = 1'b1;
		video_case(8'd224, 8'd100, 1'b0, 1'b1, 1'b0, 1'b0);
		video_case(8'd223, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0);
		video_case(8'd24, 8'd100, 1'b0, 1'b1, 1'b0, 1'b0);
		video_case(8'd25, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0);
		// Raw vblank and TV vsync
		video_case(8'd100, 8'd228, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd227, 1'b0, 1'b0, 1'b0, 1'b0);
		video_case(8'd100, 8'd251, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd252, 1'b0, 1'b0, 1'b0, 1'b0);
		video_case(8'd100, 8'd232, 1'b0, 1'b0, 1'b1, 1'b1);
		video_case(8'd100, 8'd234, 1'b0, 1'b0, 1'b1, 1'b1);
		video_case(8'd100, 8'd231, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd235, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd100, 1'b1, 1'b0, 1'b0, 1'b0);
		settings.widen_vblank = 1'b1;
		video_case(8'd100, 8'd223, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd222, 1'b0, 1'b0, 1'b0, 1'b0);
		video_case(8'd100, 8'd252, 1'b0, 1'b0, 1'b1, 1'b0);
		video_case(8'd100, 8'd253, 1'b0, 1'b0, 1'b0, 1'b0);
		// Core vsync passed through
		settings.original_vsync = 1'b1;
		video_case(8'd100, 8'd100, 1'b1, 1'b0, 1'b0, 1'b1);
		video_case(8'd100, 8'd233, 1'b0, 1'b0, 1'b1, 1'b0);
		// Hsync passes straight through
		@(negedge clk_sys);
		core.hsync = 1'b1;
		@(negedge clk_sys);
		check_bit("video hsync high", video.hsync, 1'b1);
		core.hsync = 1'b0;
		@(negedge clk_sys);
		check_bit("video hsync low", video.hsync, 1'b0);
		settings = '0;
		// Cocktail with player 2 up and then player 1 up
		write_dip(16'd254, 27'd0, 8'h10);
		video_case(8'd232, 8'd100, 1'b0, 1'b1, 1'b0, 1'b0);
		video_case(8'd231, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0);
		video_case(8'd32, 8'd100, 1'b0, 1'b1, 1'b0, 1'b0);
		video_case(8'd33, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0);
		core.player2 = 1'b0;
		video_case(8'd228, 8'd100, 1'b0, 1'b1, 1'b0, 1'b0);
		video_case(8'd28, 8'd100, 1'b0, 1'b0, 1'b0, 1'b0);
		end_test("blank_sync", start);
	endtask

	task automatic digital_test();
		int start;
		start = error_count;
		apply_reset();
		expect_pos("digital after reset", 8'd128);
		// Ten frames of right at step 4
		joy1[0] = 1'b1;
		pulse_vsync(10);
		joy1 = '0;
		expect_pos("digital after 10 slow right", 8'd88);
		apply_reset();
		settings.fast_digital = 1'b1;
		joy1[0] = 1'b1;
		pulse_vsync(10);
		joy1 = '0;
		expect_pos("digital after 10 fast right", 8'd48);
		joy1[1] = 1'b1;
		pulse_vsync(40);
		joy1 = '0;
		expect_pos("digital after long left", 8'd255);
		// Player 2 stick counts only on player 2's turn
		joy2[0] = 1'b1;
		pulse_vsync(4);
		expect_pos("digital with idle player 2 stick", 8'd255);
		core.player2 = 1'b1;
		pulse_vsync(2);
		joy2 = '0;
		expect_pos("digital after 2 player 2 right", 8'd239);
		end_test("digital", start);
	endtask

	// One spinner report for player 1
	task automatic spin_case(input int delta, input logic [1:0] speed, input logic invert,
		input pos_t expected);
		@(negedge clk_sys);
		settings.spinner_speed = speed;
		settings.p1_invert     = invert;
		spin1.delta            = 8'(delta);
		spin1.toggle           = ~spin1.toggle;
		@(negedge clk_sys);
		expect_pos($sformatf("spinner after delta %0d speed %0d invert %0b",
			delta, speed, invert), expected);
	endtask

	task automatic spinner_test();
		int start;
		start = error_count;
		apply_reset();
		settings.p1_mode = CTRL_SPINNER;
		expect_pos("spinner after reset", 8'd128);
		// Clockwise x1 goes down and anticlockwise x2 goes up
		spin_case(5, 2'd3, 1'b0, 8'd123);
		spin_case(-3, 2'd0, 1'b0, 8'd129);
		// Inverted clockwise x4 goes up
		spin_case(4, 2'd1, 1'b1, 8'd145);
		spin_case(-2, 2'd2, 1'b0, 8'd161);
		// Saturation at both ends
		spin_case(100, 2'd2, 1'b0, 8'd0);
		spin_case(-128, 2'd2, 1'b0, 8'd255);
		end_test("spinner", start);
	endtask

	// Expected bits in order coin1 coin2 p1_start_n p2_start_n p1_serve_n p2_serve_n
	task automatic button_case(input logic [7:0] j1, input logic [7:0] j2, input logic p2,
		input logic [5:0] exp_buttons);
		@(negedge clk_sys);
		joy1         = j1;
		joy2         = j2;
		core.player2 = p2;
		@(negedge clk_sys);
		check_bit("coin1", coin1, exp_buttons[5]);
		check_bit("coin2", coin2, exp_buttons[4]);
		check_bit("p1_start_n", p1_start_n, exp_buttons[3]);
		check_bit("p2_start_n", p2_start_n, exp_buttons[2]);
		check_bit("p1_serve_n", p1_serve_n, exp_buttons[1]);
		check_bit("p2_serve_n", p2_serve_n, exp_buttons[0]);
	endtask

	task automatic paddle_button_test();
		int start;
		start = error_count;
		apply_reset();
		settings.p1_mode = CTRL_PADDLE;
		settings.p2_mode = CTRL_PADDLE;
		paddle1 = 8'h30;
		paddle2 = 8'h10;
		expect_pos("paddle 1 normal", 8'hCF);
		settings.p1_invert = 1'b1;
		expect_pos("paddle 1 inverted setting", 8'h30);
		core.player2 = 1'b1;
		expect_pos("paddle 2 normal", 8'hEF);
		// Serve follows whose turn it is
		button_case(8'h80, 8'h00, 1'b0, 6'b001101);
		button_case(8'h80, 8'h00, 1'b1, 6'b001111);
		button_case(8'h00, 8'h80, 1'b1, 6'b001110);
		button_case(8'h00, 8'h80, 1'b0, 6'b001111);
		// Starts from either stick and coins per stick
		button_case(8'h40, 8'h20, 1'b0, 6'b000011);
		button_case(8'h20, 8'h50, 1'b1, 6'b010011);
		button_case(8'h10, 8'h00, 1'b0, 6'b101111);
		end_test("paddle_buttons", start);
	endtask

	initial begin
		void'($urandom(2));
		reset = 1'b1;
		drive_idle();
		apply_reset();
		dip_load_test();
		overlay_test();
		blank_sync_test();
		digital_test();
		spinner_test();
		paddle_button_test();
		$display("6 tests run, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== breakout_cabinet_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module breakout_cabinet_top import video_pkg::*, control_pkg::*; #(
	parameter int DIGITAL_STEP_SLOW = 4,
	parameter int DIGITAL_STEP_FAST = 8
) (
	input  wire               clk_sys,
	input  wire               reset,
	input  host_write_t       host_wr,
	input  cabinet_settings_t settings,
	input  core_video_t       core,
	input  wire               pad_en_n,
	// Bit 0 right, 1 left, 4 coin, 5 start1, 6 start2, 7 serve
	input  wire [7:0]         joy1,
	input  wire [7:0]         joy2,
	input  spinner_t          spin1,
	input  spinner_t          spin2,
	input  pos_t              paddle1,
	input  pos_t              paddle2,
	output video_out_t        video,
	output logic              pad_out,
	output game_switches_t    switches,
	output logic              coin1,
	output logic              coin2,
	output logic              p1_start_n,
	output logic              p2_start_n,
	output logic              p1_serve_n,
	output logic              p2_serve_n
);

	pos_t digital_pos;
	pos_t spinner_pos;

	//////////////////////////////////////////////////////////////////////
	// Cabinet buttons
	//////////////////////////////////////////////////////////////////////
	assign coin1 = joy1[4];
	assign coin2 = joy2[4];
	// Either stick may start either game
	assign p1_start_n = ~(joy1[5] | joy2[5]);
	assign p2_start_n = ~(joy1[6] | joy2[6]);
	// Serve only counts for the player whose turn it is
	assign p1_serve_n = ~joy1[7] | core.player2;
	assign p2_serve_n = ~joy2[7] | ~core.player2;

	dip_switch_loader u_dip (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.host_wr  (host_wr),
		.switches (switches)
	);

	// Cocktail colouring follows S2
	color_overlay u_overlay (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.core     (core),
		.cocktail (switches.s2),
		.settings (settings),
		.video    (video)
	);

	paddle_tracker #(
		.DIGITAL_STEP_SLOW (DIGITAL_STEP_SLOW),
		.DIGITAL_STEP_FAST (DIGITAL_STEP_FAST)
	) u_tracker (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.vsync       (core.vsync),
		.player2     (core.player2),
		.joy1_left   (joy1[1]),
		.joy1_right  (joy1[0]),
		.joy2_left   (joy2[1]),
		.joy2_right  (joy2[0]),
		.spin1       (spin1),
		.spin2       (spin2),
		.settings    (settings),
		.digital_pos (digital_pos),
		.spinner_pos (spinner_pos)
	);

	paddle_pulse_gen u_pulse (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.hsync       (core.hsync),
		.pad_en_n    (pad_en_n),
		.player2     (core.player2),
		.digital_pos (digital_pos),
		.spinner_pos (spinner_pos),
		.paddle1     (paddle1),
		.paddle2     (paddle2),
		.settings    (settings),
		.pad_out     (pad_out)
	);

endmodule

`default_nettype wire

// ==== paddle_pulse_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module paddle_pulse_gen import control_pkg::*; (
	input  wire               clk_sys,
	input  wire               reset,
	input  wire               hsync,
	input  wire               pad_en_n,
	input  wire               player2,
	input  pos_t              digital_pos,
	input  pos_t              spinner_pos,
	input  pos_t              paddle1,
	input  pos_t              paddle2,
	input  cabinet_settings_t settings,
	output logic              pad_out
);

	ctrl_mode_t mode;
	logic       invert;
	pos_t       paddle;
	pos_t       sel_pos;
	logic       hsync_old;
	logic       hsync_rise;
	logic [7:0] line_count;

	// Settings of the player now up
	assign mode   = player2 ? settings.p2_mode   : settings.p1_mode;
	assign invert = player2 ? settings.p2_invert : settings.p1_invert;
	assign paddle = player2 ? paddle2 : paddle1;

	//////////////////////////////////////////////////////////////////////
	// Position source
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		case (mode)
			CTRL_DIGITAL: sel_pos = digital_pos;
			// Analog paddle runs backwards unless inverted
			CTRL_PADDLE:  sel_pos = invert ? paddle : ~paddle;
			CTRL_SPINNER: sel_pos = spinner_pos;
			default:      sel_pos = POS_CENTER;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Line counter
	//////////////////////////////////////////////////////////////////////
	assign hsync_rise = hsync & ~hsync_old;

	// Held at zero outside the pad window, one count per line inside
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hsync_old  <= 1'b0;
			line_count <= '0;
		end else begin
			hsync_old <= hsync;
			if (!pad_en_n) begin
				line_count <= '0;
			end else if (hsync_rise) begin
				line_count <= line_count + 8'd1;
			end
		end
	end

	// Core samples the pulse width as the pad position
	assign pad_out = line_count < sel_pos;

endmodule

`default_nettype wire

// ==== paddle_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module paddle_tracker import control_pkg::*; #(
	parameter int DIGITAL_STEP_SLOW = 4,
	parameter int DIGITAL_STEP_FAST = 8
) (
	input  wire               clk_sys,
	input  wire               reset,
	input  wire               vsync,
	input  wire               player2,
	input  wire               joy1_left,
	input  wire               joy1_right,
	input  wire               joy2_left,
	input  wire               joy2_right,
	input  spinner_t          spin1,
	input  spinner_t          spin2,
	input  cabinet_settings_t settings,
	output pos_t              digital_pos,
	output pos_t              spinner_pos
);

	// Move pos by mag, clamped to 0..255
	function automatic pos_t sat_move(input pos_t pos, input logic [10:0] mag, input logic up);
		logic [11:0] sum;
		sum = {4'd0, pos} + {1'b0, mag};
		if (up) begin
			return (sum > 12'd255) ? 8'd255 : sum[7:0];
		end
		return ({3'd0, pos} < mag) ? 8'd0 : pos - mag[7:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Digital joystick, one step per frame
	//////////////////////////////////////////////////////////////////////
	logic        vsync_q;
	logic        vsync_qq;
	logic        vsync_rise;
	logic        left;
	logic        right;
	logic [10:0] step;

	assign vsync_rise = vsync_q & ~vsync_qq;
	// Only the player whose turn it is
	assign left  = player2 ? joy2_left  : joy1_left;
	assign right = player2 ? joy2_right : joy1_right;
	assign step  = settings.fast_digital ? 11'(DIGITAL_STEP_FAST) : 11'(DIGITAL_STEP_SLOW);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_q     <= 1'b0;
			vsync_qq    <= 1'b0;
			digital_pos <= POS_CENTER;
		end else begin
			vsync_q  <= vsync;
			vsync_qq <= vsync_q;
			// Left has priority when both are held
			if (vsync_rise && left) begin
				digital_pos <= sat_move(digital_pos, step, 1'b1);
			end else if (vsync_rise && right) begin
				digital_pos <= sat_move(digital_pos, step, 1'b0);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Spinner, one move per report
	//////////////////////////////////////////////////////////////////////
	logic        spin1_old;
	logic        spin2_old;
	logic        spin_flip;
	spinner_t    spin;
	logic        invert;
	logic [7:0]  spin_abs;
	logic [10:0] spin_mag;
	logic        spin_up;

	assign spin      = player2 ? spin2 : spin1;
	assign invert    = player2 ? settings.p2_invert : settings.p1_invert;
	assign spin_flip = player2 ? (spin2.toggle ^ spin2_old) : (spin1.toggle ^ spin1_old);
	// -128 comes out as 128, fits in 8 unsigned bits
	assign spin_abs  = spin.delta[7] ? (~spin.delta + 8'd1) : spin.delta;
	// Clockwise (sign clear) lowers the position
	assign spin_up   = spin.delta[7] ^ invert;

	// Speed 3 is x1, the others double per step
	always_comb begin
		case (settings.spinner_speed)
			2'd0:    spin_mag = {3'd0, spin_abs} << 1;
			2'd1:    spin_mag = {3'd0, spin_abs} << 2;
			2'd2:    spin_mag = {3'd0, spin_abs} << 3;
			default: spin_mag = {3'd0, spin_abs};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			// Track the current toggle so reset adds no move
			spin1_old   <= spin1.toggle;
			spin2_old   <= spin2.toggle;
			spinner_pos <= POS_CENTER;
		end else begin
			spin1_old <= spin1.toggle;
			spin2_old <= spin2.toggle;
			if (spin_flip) begin
				spinner_pos <= sat_move(spinner_pos, spin_mag, spin_up);
			end
		end
	end

endmodule

`default_nettype wire

// ==== color_overlay.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_overlay import video_pkg::*, control_pkg::*; (
	input  wire               clk_sys,
	input  wire               reset,
	input  core_video_t       core,
	input  wire               cocktail,
	input  cabinet_settings_t settings,
	output video_out_t        video
);

	logic lit;
	logic red_row;
	logic amber_row;
	logic green_row;
	logic yellow_row;
	logic blue_row;
	rgb_t rgb_next;
	logic hblank_p1;
	logic hblank_p2;
	logic hblank_next;
	logic vblank_next;
	logic vsync_next;

	// Any core layer lights the tube
	assign lit = core.playfield | core.ball | core.score | core.pad;

	//////////////////////////////////////////////////////////////////////
	// Overlay bands
	//////////////////////////////////////////////////////////////////////
	// Player 2 rows only exist on the cocktail overlay
	assign red_row    = in_band(core.h_count, P1_RED) |
		(cocktail & in_band(core.h_count, P2_RED));
	assign amber_row  = in_band(core.h_count, P1_AMBER) |
		(cocktail & in_band(core.h_count, P2_AMBER));
	assign green_row  = in_band(core.h_count, P1_GREEN) |
		(cocktail & in_band(core.h_count, P2_GREEN));
	assign yellow_row = in_band(core.h_count, P1_YELLOW) |
		(cocktail & in_band(core.h_count, P2_YELLOW));
	// Upright cabinet only
	assign blue_row   = in_band(core.h_count, BLUE_BAND) & ~cocktail;

	// Colour priority, first matching band wins
	always_comb begin
		if (!lit) begin
			rgb_next = COLOR_BLACK;
		end else if (red_row) begin
			rgb_next = COLOR_RED;
		end else if (amber_row) begin
			rgb_next = COLOR_AMBER;
		end else if (green_row) begin
			rgb_next = COLOR_GREEN;
		end else if (yellow_row) begin
			rgb_next = COLOR_YELLOW;
		end else if (blue_row) begin
			rgb_next = COLOR_BLUE;
		end else begin
			rgb_next = COLOR_WHITE;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Blanking and sync
	//////////////////////////////////////////////////////////////////////
	// Hblank window wraps past h_count zero
	assign hblank_p1 = (core.h_count >= HBLANK_P1_START) || (core.h_count <= HBLANK_P1_END);
	assign hblank_p2 = (core.h_count >= HBLANK_P2_START) || (core.h_count <= HBLANK_P2_END);
	// Screen is flipped for player 2 in cocktail mode
	assign hblank_next = (cocktail & core.player2) ? hblank_p2 : hblank_p1;

	assign vblank_next = settings.widen_vblank ?
		in_band(core.v_count, VBLANK_WIDE) :
		in_band(core.v_count, VBLANK_RAW);

	// Core vsync is far off NTSC, TV range is the default
	assign vsync_next = settings.original_vsync ?
		core.vsync : in_band(core.v_count, TV_VSYNC);

	// Output register
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			video <= '0;
		end else begin
			video.rgb    <= rgb_next;
			video.hblank <= hblank_next;
			video.vblank <= vblank_next;
			video.hsync  <= core.hsync;
			video.vsync  <= vsync_next;
		end
	end

endmodule

`default_nettype wire

// ==== dip_switch_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module dip_switch_loader import control_pkg::*; (
	input  wire            clk_sys,
	input  wire            reset,
	input  host_write_t    host_wr,
	output game_switches_t switches
);

	// Switch bits of DIP byte 0
	logic [6:0] dip_byte;
	logic       dip_hit;

	// Only the first byte of the DIP download is kept
	assign dip_hit = host_wr.wr &&
		(host_wr.index == DIP_INDEX) &&
		(host_wr.addr == '0);

	// Bit 7 has no switch behind it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dip_byte <= '0;
		end else if (dip_hit) begin
			dip_byte <= host_wr.data[6:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Switch decode
	//////////////////////////////////////////////////////////////////////
	// S1 is wired bit-reversed on the board
	assign switches.s1 = {dip_byte[0], dip_byte[1], dip_byte[2], dip_byte[3]};
	// Cocktail colouring
	assign switches.s2 = dip_byte[4];
	assign switches.s3 = dip_byte[5];
	assign switches.s4 = dip_byte[6];

endmodule

`default_nettype wire

// ==== control_pkg.sv ====
`default_nettype none

package control_pkg;

	// Paddle position as line count from the top of the pad area
	typedef logic [7:0] pos_t;

	// Per-player position source, OSD value is 8 bits wide
	typedef enum logic [7:0] {
		CTRL_DIGITAL = 8'd0,
		CTRL_PADDLE  = 8'd1,
		CTRL_SPINNER = 8'd2,
		CTRL_OTHER   = 8'd3
	} ctrl_mode_t;

	// Download port write from the host loader
	typedef struct packed {
		logic        wr;
		logic [15:0] index;
		logic [26:0] addr;
		logic [7:0]  data;
	} host_write_t;

	// Spinner report, toggle flips once per new delta
	typedef struct packed {
		logic              toggle;
		logic signed [7:0] delta;
	} spinner_t;

	// Cabinet options from the OSD
	typedef struct packed {
		ctrl_mode_t p1_mode;
		ctrl_mode_t p2_mode;
		logic       p1_invert;
		logic       p2_invert;
		logic       fast_digital;
		logic [1:0] spinner_speed;
		logic       widen_vblank;
		logic       original_vsync;
	} cabinet_settings_t;

	// Game board DIP switches
	typedef struct packed {
		logic [3:0] s1;
		// Cocktail two-player colouring
		logic       s2;
		logic       s3;
		logic       s4;
	} game_switches_t;

	// Loader index carrying the DIP bytes
	localparam logic [15:0] DIP_INDEX = 16'd254;
	// Mid-screen start position
	localparam pos_t POS_CENTER = 8'd128;

endpackage

`default_nettype wire

// ==== video_pkg.sv ====
`default_nettype none

package video_pkg;

	// 4:4:4 colour word driven to the video DAC
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	// Raw monochrome video and counters as they leave the game core
	typedef struct packed {
		logic       playfield;
		logic       ball;
		logic       score;
		logic       pad;
		logic       hsync;
		logic       vsync;
		logic [7:0] h_count;
		logic [7:0] v_count;
		logic       player2;
	} core_video_t;

	// Coloured video with blanking, one register stage after the core
	typedef struct packed {
		rgb_t rgb;
		logic hblank;
		logic vblank;
		logic hsync;
		logic vsync;
	} video_out_t;

	// Inclusive counter range
	typedef struct packed {
		logic [7:0] lo;
		logic [7:0] hi;
	} band_t;

	//////////////////////////////////////////////////////////////////////
	// Cellophane overlay bands on h_count (monitor is mounted sideways)
	//////////////////////////////////////////////////////////////////////
	localparam band_t P1_RED    = '{lo: 8'd64,  hi: 8'd71};
	localparam band_t P1_AMBER  = '{lo: 8'd72,  hi: 8'd79};
	localparam band_t P1_GREEN  = '{lo: 8'd80,  hi: 8'd87};
	localparam band_t P1_YELLOW = '{lo: 8'd88,  hi: 8'd95};
	// Player 2 rows mirror player 1 on the far side of the screen
	localparam band_t P2_RED    = '{lo: 8'd184, hi: 8'd191};
	localparam band_t P2_AMBER  = '{lo: 8'd176, hi: 8'd183};
	localparam band_t P2_GREEN  = '{lo: 8'd168, hi: 8'd175};
	localparam band_t P2_YELLOW = '{lo: 8'd160, hi: 8'd167};
	// Strip over the player's own paddle
	localparam band_t BLUE_BAND = '{lo: 8'd211, hi: 8'd219};

	// Overlay colours
	localparam rgb_t COLOR_RED    = 12'hA21;
	localparam rgb_t COLOR_AMBER  = 12'hC81;
	localparam rgb_t COLOR_GREEN  = 12'h173;
	localparam rgb_t COLOR_YELLOW = 12'hCC3;
	localparam rgb_t COLOR_BLUE   = 12'h17C;
	localparam rgb_t COLOR_WHITE  = 12'hFFF;
	localparam rgb_t COLOR_BLACK  = 12'h000;

	//////////////////////////////////////////////////////////////////////
	// Blanking and sync limits (core supplies none of its own)
	//////////////////////////////////////////////////////////////////////
	// Hblank wraps through zero, so start/end rather than a band
	localparam logic [7:0] HBLANK_P1_START = 8'd224;
	localparam logic [7:0] HBLANK_P1_END   = 8'd24;
	localparam logic [7:0] HBLANK_P2_START = 8'd232;
	localparam logic [7:0] HBLANK_P2_END   = 8'd32;
	localparam band_t VBLANK_RAW  = '{lo: 8'd228, hi: 8'd251};
	// Wider range hides flicker at the edges with a scan doubler
	localparam band_t VBLANK_WIDE = '{lo: 8'd223, hi: 8'd252};
	// NTSC-friendly replacement for the core's long vsync
	localparam band_t TV_VSYNC    = '{lo: 8'd232, hi: 8'd234};

	// True when count lies inside the band, both ends included
	function automatic logic in_band(input logic [7:0] count, input band_t band);
		return (count >= band.lo) && (count <= band.hi);
	endfunction

endpackage

`default_nettype wire
